//--- rtl/cart_pkg.sv
`default_nettype none

package cart_pkg;

  //////////////////////////////////////////////////////////////
  // Bus side types
  //////////////////////////////////////////////////////////////

  // One captured SNES access
  typedef struct packed {
    logic [23:0] snes_addr;  // A bus, bank in [23:16]
    logic [7:0]  snes_pa;    // B bus peripheral address
    logic        write;      // Access came from wr_n
  } snes_req_t;

  // Decoder result, also the registered output word
  typedef struct packed {
    logic [23:0] rom_addr;         // Folded and masked
    logic        rom_hit;
    logic        msu_enable;       // MSU1 regs 2000-2007
    logic        cx4_enable;       // Cx4 MMIO 6000-7fff
    logic        cx4_vect_enable;  // Vector area ffe0-ffff
    logic        r213f_enable;
    logic        snescmd_enable;   // 2a00-2aff
    logic        write;
  } decode_t;

  //////////////////////////////////////////////////////////////
  // MCU config port
  //////////////////////////////////////////////////////////////

  typedef enum logic {
    CFG_FEATURES = 1'b0,
    CFG_ROM_MASK = 1'b1
  } cfg_sel_e;

  // Feature bit view of the data word
  typedef struct packed {
    logic [23:0] rsvd;
    logic [7:0]  featurebits;
  } cfg_mode_t;

  // ROM mask view of the data word
  typedef struct packed {
    logic [7:0]  rsvd;
    logic [23:0] rom_mask;
  } cfg_mask_t;

  // Same 32 bits, read through whichever view cfg_sel names
  typedef union packed {
    cfg_mode_t mode;
    cfg_mask_t mask;
  } cfg_word_u;

  // Live configuration seen by the decoder
  typedef struct packed {
    logic [7:0]  featurebits;
    logic [23:0] rom_mask;
  } cfg_t;

  localparam logic [2:0]  FEAT_MSU1      = 3'd3;  // MSU1 register window
  localparam logic [2:0]  FEAT_213F      = 3'd4;  // 213F override
  localparam logic [23:0] ROM_MASK_RESET = 24'hff_ffff;  // Whole ROM visible

endpackage

`default_nettype wire

//--- rtl/snes_bus_sync.sv
`default_nettype none

module snes_bus_sync #(
  parameter int SYNC_STAGES = 2  // Metastability chain depth
) (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire  [23:0]           snes_addr,  // Async, stable before strobe
  input  wire  [7:0]            snes_pa,    // Async, stable before strobe
  input  wire                   snes_rd_n,
  input  wire                   snes_wr_n,
  output logic                  req_valid,  // One cycle per access
  output cart_pkg::snes_req_t   req
);

  ////////////////////////////////////////////////////////////
  // Strobe synchronizer
  ////////////////////////////////////////////////////////////

  logic                   access_raw;  // Either strobe low
  logic [SYNC_STAGES-1:0] sync_q;      // Sync chain
  logic                   sync_d;      // Edge detect history
  logic                   access_start;

  assign access_raw = ~(snes_rd_n & snes_wr_n);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;
      sync_d <= 1'b0;
    end else begin
      sync_q[0] <= access_raw;  // First sampling flop
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      sync_d <= sync_q[SYNC_STAGES-1];
    end
  end

  // Rising edge of synchronized access, i.e. strobe fell
  assign access_start = sync_q[SYNC_STAGES-1] & ~sync_d;

  ////////////////////////////////////////////////////////////
  // Request strobe and capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= access_start;
    end
  end

  // Address lines settled long before the strobe got through
  always_ff @(posedge clk) begin
    if (access_start) begin
      req.snes_addr <= snes_addr;
      req.snes_pa   <= snes_pa;
      req.write     <= ~snes_wr_n;  // Write when wr_n is the low one
    end
  end

endmodule

`default_nettype wire

//--- rtl/cart_cfg_regs.sv
`default_nettype none

module cart_cfg_regs (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   cfg_wr,    // One cycle MCU write strobe
  input  wire cart_pkg::cfg_sel_e  cfg_sel,
  input  wire cart_pkg::cfg_word_u cfg_data,
  output cart_pkg::cfg_t        cfg
);

  import cart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Config storage
  ////////////////////////////////////////////////////////////

  logic [7:0]  featurebits_q;  // MSU1, 213F etc.
  logic [23:0] rom_mask_q;     // ROM size mask

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      featurebits_q <= '0;              // All features off
      rom_mask_q    <= ROM_MASK_RESET;  // No folding until MCU says so
    end else if (cfg_wr) begin
      // Pick the view matching the target register
      case (cfg_sel)
        CFG_FEATURES: begin
          featurebits_q <= cfg_data.mode.featurebits;
        end
        CFG_ROM_MASK: begin
          rom_mask_q <= cfg_data.mask.rom_mask;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Output to decoder
  ////////////////////////////////////////////////////////////

  // New values visible from the edge after the write
  always_comb begin
    cfg.featurebits = featurebits_q;
    cfg.rom_mask    = rom_mask_q;
  end

endmodule

`default_nettype wire

//--- rtl/address.sv
`default_nettype none

module address (
  input  wire cart_pkg::snes_req_t req,
  input  wire cart_pkg::cfg_t      cfg,
  output cart_pkg::decode_t        dec
);

  import cart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Cx4 LoROM map
  ////////////////////////////////////////////////////////////
  // ROM in upper half of banks 00-3f/80-bf, all of 40-7f/c0-ff
  // MMIO at 6000-7fff below bank 40

  logic [23:0] a;          // Captured A bus address
  logic        is_rom;
  logic [23:0] lorom_addr; // Before masking

  assign a = req.snes_addr;

  // Bit 23 ignored, mirrors 80-ff onto 00-7f
  assign is_rom = a[22] | (~a[22] & a[15]);

  // Drop A15, banks become 32k pages
  assign lorom_addr = {2'b00, a[22:16], a[14:0]};

  ////////////////////////////////////////////////////////////
  // Peripheral windows
  ////////////////////////////////////////////////////////////

  logic msu_win;      // 2000-2007
  logic cx4_win;      // 6000-7fff
  logic vect_win;     // ffe0-ffff, any bank
  logic r213f_win;    // B bus 3f
  logic snescmd_win;  // 2a00-2aff

  assign msu_win     = ~a[22] & (a[15:3] == 13'h0400);
  assign cx4_win     = ~a[22] & (a[15:13] == 3'b011);
  assign vect_win    = &a[15:5];
  assign r213f_win   = (req.snes_pa == 8'h3f);
  assign snescmd_win = ~a[22] & (a[15:8] == 8'h2a);

  ////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////

  always_comb begin
    dec = '0;

    dec.rom_addr = lorom_addr & cfg.rom_mask;  // Wrap to ROM size
    dec.rom_hit  = is_rom;                     // No save RAM in Cx4 map

    // Feature gating lives only here
    dec.msu_enable   = cfg.featurebits[FEAT_MSU1] & msu_win;
    dec.r213f_enable = cfg.featurebits[FEAT_213F] & r213f_win;

    dec.cx4_enable      = cx4_win;
    dec.cx4_vect_enable = vect_win;
    dec.snescmd_enable  = snescmd_win;

    dec.write = req.write;  // Pass through
  end

endmodule

`default_nettype wire

//--- rtl/access_out.sv
`default_nettype none

module access_out (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire                    req_valid,  // Decode is valid this cycle
  input  wire cart_pkg::decode_t dec,
  output logic                   out_valid,  // ROM request strobe
  output cart_pkg::decode_t      out
);

  ////////////////////////////////////////////////////////////
  // Strobe
  ////////////////////////////////////////////////////////////

  // One cycle behind req_valid, one per access
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= req_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Held decode result
  ////////////////////////////////////////////////////////////

  // Selects stay put between strobes, no decoder glitches reach
  // the memory controller
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out <= '0;
    end else if (req_valid) begin
      out <= dec;  // Capture on request only
    end
  end

endmodule

`default_nettype wire

//--- rtl/snes_cart_top.sv
`default_nettype none

module snes_cart_top #(
  parameter int SYNC_STAGES = 2  // Passed to bus sync
) (
  input  wire                      clk,
  input  wire                      arst_n,
  // SNES bus, asynchronous
  input  wire  [23:0]              snes_addr,
  input  wire  [7:0]               snes_pa,
  input  wire                      snes_rd_n,
  input  wire                      snes_wr_n,
  // MCU config port
  input  wire                      cfg_wr,
  input  wire cart_pkg::cfg_sel_e  cfg_sel,
  input  wire cart_pkg::cfg_word_u cfg_data,
  // Decoded access
  output logic                     out_valid,
  output cart_pkg::decode_t        out
);

  import cart_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////

  logic      req_valid;  // Access start strobe
  snes_req_t req;        // Captured address
  cfg_t      cfg;        // Live config
  decode_t   dec;        // Combinational decode

  snes_bus_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_bus_sync (
    .clk       (clk),
    .arst_n    (arst_n),
    .snes_addr (snes_addr),
    .snes_pa   (snes_pa),
    .snes_rd_n (snes_rd_n),
    .snes_wr_n (snes_wr_n),
    .req_valid (req_valid),
    .req       (req)
  );

  cart_cfg_regs u_cfg_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .cfg_wr   (cfg_wr),
    .cfg_sel  (cfg_sel),
    .cfg_data (cfg_data),
    .cfg      (cfg)
  );

  // Zero cycle decoder
  address u_address (
    .req (req),
    .cfg (cfg),
    .dec (dec)
  );

  access_out u_access_out (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .dec       (dec),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

//--- test/tb_snes_cart.sv
`default_nettype none

module tb_snes_cart;

  timeunit 1ns;
  timeprecision 100ps;

  import cart_pkg::*;

  localparam int SYNC_STAGES = 2;

  // Accesses per test, watchdog scales with the sum
  localparam int N_T1 = 18;
  localparam int N_T2 = 24;
  localparam int N_T3 = 15;
  localparam int N_T4 = 17;
  localparam int N_T5 = 20;
  localparam int N_ACCESS = N_T1 + N_T2 + N_T3 + N_T4 + N_T5;
  localparam int WATCHDOG_CYCLES = N_ACCESS * 20 + 200;

  logic        clk;
  logic        arst_n;
  logic [23:0] snes_addr;
  logic [7:0]  snes_pa;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        cfg_wr;
  cfg_sel_e    cfg_sel;
  cfg_word_u   cfg_data;
  logic        out_valid;
  decode_t     out;

  decode_t     exp_q[$];   // Expected results, oldest first
  string       name_q[$];  // Test name per entry
  string       test_name;
  logic [7:0]  model_features;  // Mirror of the config block
  logic [23:0] model_mask;
  int          errors;
  int          checks;

  snes_cart_top #(
    .SYNC_STAGES (SYNC_STAGES)
  ) i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .snes_addr (snes_addr),
    .snes_pa   (snes_pa),
    .snes_rd_n (snes_rd_n),
    .snes_wr_n (snes_wr_n),
    .cfg_wr    (cfg_wr),
    .cfg_sel   (cfg_sel),
    .cfg_data  (cfg_data),
    .out_valid (out_valid),
    .out       (out)
  );

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic decode_t decode_ref(input logic [23:0] addr, input logic [7:0] pa,
                                         input logic write, input logic [7:0] featurebits,
                                         input logic [23:0] rom_mask);
    decode_t     d;
    logic [15:0] off;
    logic        low_bank;  // Banks 00-3f and 80-bf
    d        = '0;
    off      = addr[15:0];
    low_bank = (addr[22] == 1'b0);
    d.rom_hit  = !low_bank || (off >= 16'h8000);
    d.rom_addr = {2'b00, addr[22:16], addr[14:0]} & rom_mask;
    d.msu_enable = featurebits[FEAT_MSU1] && low_bank && (off >= 16'h2000)
                   && (off <= 16'h2007);
    d.cx4_enable      = low_bank && (off >= 16'h6000) && (off <= 16'h7fff);
    d.cx4_vect_enable = (off >= 16'hffe0);  // Any bank
    d.r213f_enable    = featurebits[FEAT_213F] && (pa == 8'h3f);
    d.snescmd_enable  = low_bank && (off[15:8] == 8'h2a);
    d.write           = write;
    return d;
  endfunction

  function automatic logic [31:0] rand_word();
    return $urandom();
  endfunction

  function automatic logic [23:0] rand_rom_addr();
    logic [31:0] r;
    logic [23:0] a;
    r = rand_word();
    a = r[23:0];
    if (!a[22]) a[15] = 1'b1;  // Low banks hold ROM in upper half only
    return a;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic write_cfg(input cfg_sel_e sel, input logic [23:0] value);
    @(negedge clk);
    cfg_data = '0;
    cfg_sel  = sel;
    if (sel == CFG_FEATURES) begin
      cfg_data.mode.featurebits = value[7:0];
      model_features = value[7:0];
    end else begin
      cfg_data.mask.rom_mask = value;
      model_mask = value;
    end
    cfg_wr = 1'b1;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  // One bus access; expectation queued before the strobe so it is there in time
  task automatic do_access(input logic [23:0] addr, input logic [7:0] pa, input logic wr);
    @(negedge clk);
    snes_addr = addr;
    snes_pa   = pa;
    exp_q.push_back(decode_ref(addr, pa, wr, model_features, model_mask));
    name_q.push_back(test_name);
    @(negedge clk);
    if (wr) snes_wr_n = 1'b0;
    else snes_rd_n = 1'b0;
    repeat (SYNC_STAGES + 3) @(negedge clk);
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  task automatic report_addr_mismatch(input string name, input logic [23:0] exp_v,
                                      input logic [23:0] act_v);
    errors++;
    $display("CHECK FAILED %s rom_addr: expected %h, got %h", name, exp_v, act_v);
  endtask

  task automatic report_flag_mismatch(input string name, input string field,
                                      input logic exp_v, input logic act_v);
    errors++;
    $display("CHECK FAILED %s %s: expected %b, got %b", name, field, exp_v, act_v);
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process, samples on falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    decode_t exp_d;
    string   name;
    if (arst_n && out_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Extra out_valid at %0t with no access pending", $time);
      end else begin
        exp_d = exp_q.pop_front();
        name  = name_q.pop_front();
        checks++;
        if (out.rom_addr !== exp_d.rom_addr)
          report_addr_mismatch(name, exp_d.rom_addr, out.rom_addr);
        if (out.rom_hit !== exp_d.rom_hit)
          report_flag_mismatch(name, "rom_hit", exp_d.rom_hit, out.rom_hit);
        if (out.msu_enable !== exp_d.msu_enable)
          report_flag_mismatch(name, "msu_enable", exp_d.msu_enable, out.msu_enable);
        if (out.cx4_enable !== exp_d.cx4_enable)
          report_flag_mismatch(name, "cx4_enable", exp_d.cx4_enable, out.cx4_enable);
        if (out.cx4_vect_enable !== exp_d.cx4_vect_enable)
          report_flag_mismatch(name, "cx4_vect_enable", exp_d.cx4_vect_enable,
                               out.cx4_vect_enable);
        if (out.r213f_enable !== exp_d.r213f_enable)
          report_flag_mismatch(name, "r213f_enable", exp_d.r213f_enable, out.r213f_enable);
        if (out.snescmd_enable !== exp_d.snescmd_enable)
          report_flag_mismatch(name, "snescmd_enable", exp_d.snescmd_enable,
                               out.snescmd_enable);
        if (out.write !== exp_d.write)
          report_flag_mismatch(name, "write", exp_d.write, out.write);
      end
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, accesses did not complete", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    void'($urandom(3));
    clk = 1'b0;
    arst_n = 1'b0;
    snes_addr = '0;
    snes_pa = '0;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    cfg_wr = 1'b0;
    cfg_sel = CFG_FEATURES;
    cfg_data = '0;
    model_features = '0;        // Reset values of the config block
    model_mask = 24'hff_ffff;
    errors = 0;
    checks = 0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    test_name = "reset_rom";  // Unmasked fold, features off
    for (int i = 0; i < N_T1 - 2; i++) do_access(rand_rom_addr(), 8'h00, 1'b0);
    do_access(24'h00_2003, 8'h3f, 1'b0);  // Inside MSU1 and 213F windows
    do_access(24'h80_2007, 8'h3f, 1'b1);

    test_name = "rom_mask";
    write_cfg(CFG_ROM_MASK, 24'h0f_ffff);  // 1 MB ROM
    for (int i = 0; i < N_T2; i++) begin
      r = rand_word();
      do_access(r[23:0], 8'h00, 1'b0);
    end

    test_name = "window_edges";
    do_access(24'h00_5fff, 8'h00, 1'b0);
    do_access(24'h00_6000, 8'h00, 1'b0);
    do_access(24'h00_7fff, 8'h00, 1'b0);
    do_access(24'h00_8000, 8'h00, 1'b0);
    do_access(24'h00_ffe0, 8'h00, 1'b0);
    do_access(24'h00_ffdf, 8'h00, 1'b0);
    do_access(24'h00_2a00, 8'h00, 1'b0);
    do_access(24'h00_2aff, 8'h00, 1'b0);
    do_access(24'h00_29ff, 8'h00, 1'b0);
    do_access(24'h00_2b00, 8'h00, 1'b0);
    do_access(24'h40_6000, 8'h00, 1'b0);  // Bank 40 up is all ROM
    do_access(24'h40_2a00, 8'h00, 1'b0);
    do_access(24'h40_ffe0, 8'h00, 1'b0);
    do_access(24'hc0_7fff, 8'h00, 1'b0);
    do_access(24'h3f_6000, 8'h00, 1'b0);

    test_name = "features";
    write_cfg(CFG_FEATURES, 24'h00_0018);  // MSU1 and 213F on
    do_access(24'h00_1fff, 8'h00, 1'b0);
    do_access(24'h00_2000, 8'h00, 1'b0);
    do_access(24'h00_2007, 8'h00, 1'b1);
    do_access(24'h00_2008, 8'h00, 1'b0);
    do_access(24'h80_2004, 8'h00, 1'b0);
    do_access(24'h40_2003, 8'h00, 1'b0);
    do_access(24'h00_8000, 8'h3f, 1'b0);
    do_access(24'h00_8000, 8'h3e, 1'b0);
    do_access(24'h00_8000, 8'hbf, 1'b0);
    for (int i = 0; i < N_T4 - 9; i++) begin
      r = rand_word();
      // Half the time land in the MSU1 window or on pa 3f
      if (r[31]) do_access({r[23:16], 13'h0400, r[2:0]}, 8'h3f, 1'b0);
      else do_access(r[23:0], r[30:23], 1'b0);
    end

    test_name = "mixed_rw";
    write_cfg(CFG_ROM_MASK, 24'h3f_ffff);
    for (int i = 0; i < N_T5; i++) begin
      r = rand_word();
      w = rand_word();
      do_access(r[23:0], w[7:0], w[8]);
    end

    repeat (SYNC_STAGES + 6) @(negedge clk);  // Drain the pipeline
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d accesses never produced out_valid", exp_q.size());
    end
    $display("Checked %0d results, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- snes_cart.f
rtl/cart_pkg.sv
rtl/snes_bus_sync.sv
rtl/cart_cfg_regs.sv
rtl/address.sv
rtl/access_out.sv
rtl/snes_cart_top.sv
test/tb_snes_cart.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_snes_cart --timescale 1ns/100ps \
  -Mdir obj_dir -f snes_cart.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_snes_cart)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
